//--- files.f
+incdir+logic
logic/wbq_cache_pkg.sv
logic/wbq_bus_pkg.sv
logic/wbq_slot_if.sv
logic/beat_counter.sv
logic/drain_fsm.sv
logic/victim_store.sv
logic/writeback_queue.sv
verification/tb_writeback_queue.sv

//--- logic/beat_counter.sv
`include "wbq_config.svh"

module beat_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  wbq_bus_pkg::drain_state_t state,
    input  logic                      beat_done,
    output wbq_bus_pkg::beat_idx_t    beat,
    output logic                      last
);
    import wbq_bus_pkg::*;

    logic next_is_last;

    // Accepting the second to last beat means the final one is offered next.
    assign next_is_last = (beat == beat_idx_t'(`WBQ_LINE_WORDS - 2));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat <= '0;
            last <= 1'b0;
        end else if (state != st_write) begin
            beat <= '0;
            last <= 1'b0;
        end else if (beat_done) begin
            beat <= beat + 1'b1;
            last <= next_is_last; // Drops again once the final beat is taken.
        end
    end

endmodule

//--- logic/drain_fsm.sv
`include "wbq_config.svh"

module drain_fsm (
    input  logic                      clk,
    input  logic                      rst,
    wbq_slot_if.drain                 slot,
    output logic                      aw_valid,
    input  logic                      aw_ready,
    output wbq_cache_pkg::byte_addr_t aw_addr,
    output wbq_bus_pkg::bus_op_t      aw_op,
    output logic                      w_valid,
    input  logic                      w_ready,
    output wbq_cache_pkg::word_t      w_data,
    output logic                      w_last,
    input  logic                      b_valid
);
    import wbq_cache_pkg::*;
    import wbq_bus_pkg::*;

    drain_state_t state;
    line_addr_t   addr_q;
    line_t        line_q;
    logic         dirty_q;
    beat_idx_t    beat;
    logic         beat_done;

    assign slot.claim  = (state == st_idle) && slot.ready;
    assign slot.busy   = (state != st_idle);
    assign slot.retire = (state == st_retire);

    assign beat_done = w_valid & w_ready;

    beat_counter u_beats (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .beat_done (beat_done),
        .beat      (beat),
        .last      (w_last)
    );

    // Captured line drives the bus, so it stays put under back-pressure.
    assign aw_addr = {addr_q, {`WBQ_OFFSET_W{1'b0}}};
    assign aw_op   = dirty_q ? op_write_clean : op_write_evict;
    assign w_data  = line_q[beat];

    always_ff @(posedge clk) begin
        if (slot.claim) begin
            addr_q  <= slot.pick_addr;
            line_q  <= slot.pick_line;
            dirty_q <= slot.pick_dirty;
        end
    end

    // ------------------------------
    // Burst sequencing
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (slot.ready) begin
                        aw_valid <= 1'b1;
                        state    <= st_address;
                    end
                end
                st_address: begin
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                        if (dirty_q) begin
                            w_valid <= 1'b1;
                            state   <= st_write;
                        end else begin
                            state <= st_retire; // Evict carries no data.
                        end
                    end
                end
                st_write: begin
                    if (beat_done && w_last) begin
                        w_valid <= 1'b0;
                        state   <= st_wait_resp;
                    end
                end
                st_wait_resp: begin
                    if (b_valid) begin
                        state <= st_retire;
                    end
                end
                st_retire: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

endmodule

//--- logic/victim_store.sv
`include "wbq_config.svh"

module victim_store (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc_en,
    input  wbq_cache_pkg::line_addr_t alloc_addr,
    output logic                     alloc_hit,
    output wbq_cache_pkg::slot_idx_t  alloc_idx,
    output logic                     full,
    input  logic                     refill_en,
    input  wbq_cache_pkg::slot_idx_t  refill_idx,
    input  wbq_cache_pkg::line_t      refill_line,
    input  logic                     refill_dirty,
    input  logic                     snoop_en,
    input  logic                     snoop_clean,
    input  wbq_cache_pkg::line_addr_t snoop_addr,
    output logic                     snoop_hit,
    output wbq_cache_pkg::line_t      snoop_line,
    output logic                     snoop_dirty,
    wbq_slot_if.store                slot
);
    import wbq_cache_pkg::*;

    line_addr_t slot_addr [`WBQ_SLOTS];
    line_t      slot_line [`WBQ_SLOTS];
    slot_mask_t pending;
    slot_mask_t refilled;
    slot_mask_t urgent;
    slot_mask_t dirty;

    slot_mask_t alloc_match;
    slot_mask_t snoop_match;
    slot_mask_t ready_mask;
    slot_mask_t urgent_mask;
    slot_idx_t  free_idx;
    slot_idx_t  hit_idx;
    slot_idx_t  snoop_idx;
    slot_idx_t  active_idx;
    logic       clean_blocked;

    // Lowest set bit wins.
    function automatic slot_idx_t lowest_idx(input slot_mask_t mask);
        slot_idx_t idx;
        idx = '0;
        for (int i = `WBQ_SLOTS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = slot_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ------------------------------
    // Address lookup
    // ------------------------------
    always_comb begin
        for (int i = 0; i < `WBQ_SLOTS; i++) begin
            alloc_match[i] = pending[i] & refilled[i] & (slot_addr[i] == alloc_addr);
            snoop_match[i] = pending[i] & refilled[i] & (slot_addr[i] == snoop_addr);
        end
    end

    assign free_idx  = lowest_idx(~pending);
    assign hit_idx   = lowest_idx(alloc_match);
    assign snoop_idx = lowest_idx(snoop_match);

    // The slot under drain, or the one being claimed right now, must survive a clean.
    assign clean_blocked = (slot.busy && snoop_idx == active_idx) ||
                           (slot.claim && snoop_idx == slot.pick_idx);

    // ------------------------------
    // Drain selection
    // ------------------------------
    assign ready_mask  = pending & refilled;
    assign urgent_mask = ready_mask & urgent;

    assign slot.ready      = |ready_mask;
    assign slot.pick_idx   = (|urgent_mask) ? lowest_idx(urgent_mask) : lowest_idx(ready_mask);
    assign slot.pick_addr  = slot_addr[slot.pick_idx];
    assign slot.pick_line  = slot_line[slot.pick_idx];
    assign slot.pick_dirty = dirty[slot.pick_idx];

    // ------------------------------
    // Slot state
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending    <= '0;
            refilled   <= '0;
            urgent     <= '0;
            dirty      <= '0;
            alloc_hit  <= 1'b0;
            alloc_idx  <= '0;
            full       <= 1'b0;
            active_idx <= '0;
        end else begin
            full <= &pending; // Lags occupancy by one cycle.

            if (alloc_en) begin
                if (|alloc_match) begin
                    alloc_hit       <= 1'b1;
                    alloc_idx       <= hit_idx;
                    urgent[hit_idx] <= 1'b1; // A later eviction is waiting on this line.
                end else if (!(&pending)) begin
                    alloc_hit          <= 1'b0;
                    alloc_idx          <= free_idx;
                    pending[free_idx]  <= 1'b1;
                    refilled[free_idx] <= 1'b0;
                    urgent[free_idx]   <= 1'b0;
                    dirty[free_idx]    <= 1'b0;
                end else begin
                    alloc_hit <= 1'b0;
                end
            end

            if (refill_en) begin
                refilled[refill_idx] <= 1'b1;
                dirty[refill_idx]    <= refill_dirty;
            end

            if (slot.claim) begin
                active_idx <= slot.pick_idx;
            end

            if (snoop_en && snoop_clean && (|snoop_match) && !clean_blocked) begin
                pending[snoop_idx]  <= 1'b0;
                refilled[snoop_idx] <= 1'b0;
                urgent[snoop_idx]   <= 1'b0;
                dirty[snoop_idx]    <= 1'b0;
            end

            if (slot.retire) begin
                pending[active_idx]  <= 1'b0;
                refilled[active_idx] <= 1'b0;
                urgent[active_idx]   <= 1'b0;
                dirty[active_idx]    <= 1'b0;
            end
        end
    end

    // Line storage and snoop data.
    always_ff @(posedge clk) begin
        if (alloc_en && !(|alloc_match) && !(&pending)) begin
            slot_addr[free_idx] <= alloc_addr;
        end
        if (refill_en) begin
            slot_line[refill_idx] <= refill_line;
        end
        if (snoop_en) begin
            snoop_line  <= slot_line[snoop_idx];
            snoop_dirty <= dirty[snoop_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snoop_hit <= 1'b0;
        end else if (snoop_en) begin
            snoop_hit <= |snoop_match; // Held until the next lookup.
        end
    end

endmodule

//--- logic/wbq_bus_pkg.sv
`include "wbq_config.svh"

package wbq_bus_pkg;

    typedef logic [`WBQ_BEAT_W-1:0] beat_idx_t;

    // Dirty lines are written back, clean lines only announce the eviction.
    typedef enum logic {
        op_write_clean,
        op_write_evict
    } bus_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_address,
        st_write,
        st_wait_resp,
        st_retire
    } drain_state_t;

endpackage

//--- logic/wbq_cache_pkg.sv
`include "wbq_config.svh"

package wbq_cache_pkg;

    // Line address is the byte address with the line offset removed.
    typedef logic [`WBQ_ADDR_W-`WBQ_OFFSET_W-1:0] line_addr_t;

    typedef logic [`WBQ_ADDR_W-1:0] byte_addr_t;

    typedef logic [`WBQ_WORD_W-1:0] word_t;

    // Word 0 sits in the low bits of the line.
    typedef logic [`WBQ_LINE_WORDS-1:0][`WBQ_WORD_W-1:0] line_t;

    typedef logic [`WBQ_SLOT_W-1:0] slot_idx_t;

    typedef logic [`WBQ_SLOTS-1:0] slot_mask_t; // One bit per slot.

endpackage

//--- logic/wbq_config.svh
`ifndef WBQ_CONFIG_SVH
`define WBQ_CONFIG_SVH

// ------------------------------
// Victim store geometry
// ------------------------------
`define WBQ_SLOTS 4
`define WBQ_SLOT_W 2

// ------------------------------
// Line and burst shape
// ------------------------------
`define WBQ_LINE_WORDS 4
`define WBQ_BEAT_W 2
`define WBQ_WORD_W 32

// ------------------------------
// Addressing
// ------------------------------
`define WBQ_ADDR_W 32
`define WBQ_OFFSET_W 4 // Byte offset inside one line.

`endif

//--- logic/wbq_slot_if.sv
interface wbq_slot_if;
    import wbq_cache_pkg::*;

    // Driven by the store.
    logic       ready;
    slot_idx_t  pick_idx;
    line_addr_t pick_addr;
    line_t      pick_line;
    logic       pick_dirty;

    // Driven by the drain engine.
    logic claim;
    logic busy;
    logic retire;

    modport store (
        output ready, pick_idx, pick_addr, pick_line, pick_dirty,
        input  claim, busy, retire
    );

    modport drain (
        input  ready, pick_idx, pick_addr, pick_line, pick_dirty,
        output claim, busy, retire
    );

endinterface

//--- logic/writeback_queue.sv
module writeback_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_en,
    input  wbq_cache_pkg::line_addr_t alloc_addr,
    output logic                      alloc_hit,
    output wbq_cache_pkg::slot_idx_t  alloc_idx,
    output logic                      full,
    input  logic                      refill_en,
    input  wbq_cache_pkg::slot_idx_t  refill_idx,
    input  wbq_cache_pkg::line_t      refill_line,
    input  logic                      refill_dirty,
    input  logic                      snoop_en,
    input  logic                      snoop_clean,
    input  wbq_cache_pkg::line_addr_t snoop_addr,
    output logic                      snoop_hit,
    output wbq_cache_pkg::line_t      snoop_line,
    output logic                      snoop_dirty,
    output logic                      aw_valid,
    input  logic                      aw_ready,
    output wbq_cache_pkg::byte_addr_t aw_addr,
    output wbq_bus_pkg::bus_op_t      aw_op,
    output logic                      w_valid,
    input  logic                      w_ready,
    output wbq_cache_pkg::word_t      w_data,
    output logic                      w_last,
    input  logic                      b_valid
);

    wbq_slot_if slot_bus ();

    victim_store u_store (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc_addr   (alloc_addr),
        .alloc_hit    (alloc_hit),
        .alloc_idx    (alloc_idx),
        .full         (full),
        .refill_en    (refill_en),
        .refill_idx   (refill_idx),
        .refill_line  (refill_line),
        .refill_dirty (refill_dirty),
        .snoop_en     (snoop_en),
        .snoop_clean  (snoop_clean),
        .snoop_addr   (snoop_addr),
        .snoop_hit    (snoop_hit),
        .snoop_line   (snoop_line),
        .snoop_dirty  (snoop_dirty),
        .slot         (slot_bus.store)
    );

    drain_fsm u_drain (
        .clk      (clk),
        .rst      (rst),
        .slot     (slot_bus.drain),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .aw_op    (aw_op),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_last   (w_last),
        .b_valid  (b_valid)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator and run; the result comes from the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_writeback_queue -o sim_wbq \
    && ./obj_dir/sim_wbq | grep -F "** PASS **" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verification/tb_writeback_queue.sv
`include "wbq_config.svh"

module tb_writeback_queue;
    import wbq_cache_pkg::*;
    import wbq_bus_pkg::*;

    localparam int line_count  = 10;
    localparam int beat_count  = 24;
    localparam int cycle_limit = 20 * (line_count + beat_count);

    logic clk = 1'b0;
    logic rst, alloc_en, alloc_hit, full, refill_en, refill_dirty;
    logic snoop_en, snoop_clean, snoop_hit, snoop_dirty;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid;
    line_addr_t alloc_addr, snoop_addr;
    slot_idx_t  alloc_idx, refill_idx;
    line_t      refill_line, snoop_line;
    byte_addr_t aw_addr;
    bus_op_t    aw_op;
    word_t      w_data;

    // Reference model of the slots and the drain engine.
    line_addr_t m_addr [`WBQ_SLOTS];
    line_t      m_line [`WBQ_SLOTS];
    slot_mask_t m_pend = '0, m_refd = '0, m_urg = '0, m_dirty = '0;
    int         m_phase = 0;
    int         m_beat = 0;
    slot_idx_t  m_act = '0;
    line_addr_t m_act_addr = '0;
    logic       m_act_dirty = 1'b0;
    line_addr_t drained [$];
    logic       e_full = 1'b0, e_hit = 1'b0, e_shit = 1'b0, e_sdirty = 1'b0;
    logic       chk_alloc = 1'b0, chk_snoop = 1'b0;
    slot_idx_t  e_idx = '0;
    line_t      e_sline = '0;
    string      test_name = "reset";
    logic [31:0] rng_state = 32'd56247;
    logic       stall = 1'b0, resp_wait = 1'b0;
    logic [1:0] resp_delay = '0;
    int         bursts_done = 0;
    int         bursts_answered = 0;
    int         cycles = 0;

    writeback_queue uut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected word of a line at a given beat; also the refill data.
    function automatic word_t ref_word(input line_addr_t addr, input beat_idx_t beat);
        return ({4'h0, addr} * 32'h9e3779b1) ^ {beat, 30'h0} ^ {30'h0, beat};
    endfunction

    function automatic line_t make_line(input line_addr_t addr);
        line_t l;
        for (int b = 0; b < `WBQ_LINE_WORDS; b++) begin
            l[b] = ref_word(addr, beat_idx_t'(b));
        end
        return l;
    endfunction

    function automatic slot_idx_t lowest_set(input slot_mask_t mask);
        slot_idx_t idx;
        idx = '0;
        for (int i = `WBQ_SLOTS - 1; i >= 0; i--) begin
            if (mask[i]) idx = slot_idx_t'(i);
        end
        return idx;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("Mismatch in %s on %s: expected %h, actual %h", test_name, what, exp, act);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    // ------------------------------
    // Bus responder
    // ------------------------------
    always @(negedge clk) begin
        rng_state = xorshift(rng_state);
        aw_ready  = !stall && rng_state[0];
        w_ready   = rng_state[1] | rng_state[2];
        b_valid   = 1'b0;
        if (bursts_answered != bursts_done) begin
            bursts_answered = bursts_done;
            rng_state  = xorshift(rng_state);
            resp_delay = rng_state[1:0]; // Response comes 0 to 3 cycles late.
            resp_wait  = 1'b1;
        end
        if (resp_wait) begin
            if (resp_delay == 2'd0) begin
                b_valid   = 1'b1;
                resp_wait = 1'b0;
            end else begin
                resp_delay = resp_delay - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the queue never went idle.", cycles);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------
    // Model step and checker
    // ------------------------------
    always @(posedge clk) begin : model
        slot_mask_t ready, urg, amatch, smatch;
        logic       claim, blocked, pick_dirty;
        slot_idx_t  pick, sidx, fidx;
        line_addr_t pick_addr;
        if (!rst) begin
            assert (full == e_full) else report_mismatch("full", 128'(e_full), 128'(full));
            if (chk_alloc) begin
                assert (alloc_hit == e_hit)
                    else report_mismatch("alloc_hit", 128'(e_hit), 128'(alloc_hit));
                assert (alloc_idx == e_idx)
                    else report_mismatch("alloc_idx", 128'(e_idx), 128'(alloc_idx));
            end
            if (chk_snoop) begin
                assert (snoop_hit == e_shit)
                    else report_mismatch("snoop_hit", 128'(e_shit), 128'(snoop_hit));
                if (e_shit) begin
                    assert (snoop_line == e_sline)
                        else report_mismatch("snoop_line", e_sline, snoop_line);
                    assert (snoop_dirty == e_sdirty)
                        else report_mismatch("snoop_dirty", 128'(e_sdirty), 128'(snoop_dirty));
                end
            end
            ready = m_pend & m_refd;
            urg   = ready & m_urg;
            claim = (m_phase == 0) && (ready != '0);
            pick  = (urg != '0) ? lowest_set(urg) : lowest_set(ready); // Urgent first.
            pick_addr  = m_addr[pick];
            pick_dirty = m_dirty[pick];
            for (int i = 0; i < `WBQ_SLOTS; i++) begin
                amatch[i] = ready[i] && (m_addr[i] == alloc_addr);
                smatch[i] = ready[i] && (m_addr[i] == snoop_addr);
            end
            sidx    = lowest_set(smatch);
            fidx    = lowest_set(~m_pend);
            blocked = (m_phase != 0 && sidx == m_act) || (claim && sidx == pick);

            if (aw_valid) begin
                assert (m_phase == 1) else report_error("aw_valid outside an address phase");
                assert (aw_addr == {m_act_addr, 4'h0})
                    else report_mismatch("aw_addr", 128'({m_act_addr, 4'h0}), 128'(aw_addr));
                assert (aw_op == (m_act_dirty ? op_write_clean : op_write_evict))
                    else report_mismatch("aw_op", 128'(!m_act_dirty), 128'(aw_op));
            end
            if (w_valid) begin
                assert (m_phase == 2) else report_error("w_valid without a dirty burst");
                assert (w_data == ref_word(m_act_addr, beat_idx_t'(m_beat)))
                    else report_mismatch("w_data",
                        128'(ref_word(m_act_addr, beat_idx_t'(m_beat))), 128'(w_data));
                assert (w_last == (m_beat == 3))
                    else report_mismatch("w_last", 128'(m_beat == 3), 128'(w_last));
            end

            e_full    = &m_pend; // Registered, so it trails occupancy.
            chk_alloc = alloc_en;
            chk_snoop = snoop_en;
            if (snoop_en) begin
                e_shit   = |smatch;
                e_sline  = m_line[sidx];
                e_sdirty = m_dirty[sidx];
                if (snoop_clean && e_shit && !blocked) begin
                    m_pend[sidx] = 1'b0;
                    m_refd[sidx] = 1'b0;
                    m_urg[sidx]  = 1'b0;
                end
            end
            if (alloc_en) begin
                if (amatch != '0) begin
                    e_hit = 1'b1;
                    e_idx = lowest_set(amatch);
                    m_urg[e_idx] = 1'b1;
                end else if (!(&m_pend)) begin
                    e_hit = 1'b0;
                    e_idx = fidx;
                    m_pend[fidx]  = 1'b1;
                    m_refd[fidx]  = 1'b0;
                    m_urg[fidx]   = 1'b0;
                    m_dirty[fidx] = 1'b0;
                    m_addr[fidx]  = alloc_addr;
                end else begin
                    e_hit = 1'b0;
                end
            end
            if (refill_en) begin
                m_refd[refill_idx]  = 1'b1;
                m_dirty[refill_idx] = refill_dirty;
                m_line[refill_idx]  = refill_line;
            end

            case (m_phase)
                0: if (claim) begin
                    m_phase     = 1;
                    m_act       = pick;
                    m_act_addr  = pick_addr;
                    m_act_dirty = pick_dirty;
                end
                1: if (aw_valid && aw_ready) begin
                    drained.push_back(aw_addr[`WBQ_ADDR_W-1:`WBQ_OFFSET_W]);
                    m_phase = m_act_dirty ? 2 : 4;
                end
                2: if (w_valid && w_ready) begin
                    if (m_beat == 3) begin
                        m_phase = 3;
                        m_beat  = 0;
                        bursts_done++;
                    end else begin
                        m_beat++;
                    end
                end
                3: if (b_valid) m_phase = 4;
                default: begin
                    m_pend[m_act] = 1'b0; // Retire frees the slot.
                    m_refd[m_act] = 1'b0;
                    m_urg[m_act]  = 1'b0;
                    m_phase = 0;
                end
            endcase
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic alloc(input line_addr_t addr);
        alloc_en   = 1'b1;
        alloc_addr = addr;
        @(negedge clk);
        alloc_en = 1'b0;
    endtask

    task automatic refill(input slot_idx_t idx, input line_addr_t addr, input logic dirty);
        refill_en    = 1'b1;
        refill_idx   = idx;
        refill_line  = make_line(addr);
        refill_dirty = dirty;
        @(negedge clk);
        refill_en = 1'b0;
    endtask

    task automatic snoop(input line_addr_t addr, input logic clean);
        snoop_en    = 1'b1;
        snoop_clean = clean;
        snoop_addr  = addr;
        @(negedge clk);
        snoop_en    = 1'b0;
        snoop_clean = 1'b0;
    endtask

    task automatic wait_idle();
        while (m_phase != 0 || (m_pend & m_refd) != '0) @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        alloc_en = 1'b0;
        alloc_addr = '0;
        refill_en = 1'b0;
        refill_idx = '0;
        refill_line = '0;
        refill_dirty = 1'b0;
        snoop_en = 1'b0;
        snoop_clean = 1'b0;
        snoop_addr = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "dirty_drain";
        alloc(28'h0001000);
        refill(2'd0, 28'h0001000, 1'b1);
        wait_idle();

        test_name = "clean_drain";
        alloc(28'h0001010);
        refill(2'd0, 28'h0001010, 1'b0);
        wait_idle();

        test_name = "alloc_full";
        alloc(28'h0002000);
        alloc(28'h0002010);
        alloc(28'h0002020);
        alloc(28'h0002030);
        @(negedge clk);
        assert (full) else report_mismatch("full", 128'(1), 128'(full));
        alloc(28'h0002040);
        assert (!alloc_hit) else report_mismatch("alloc_hit", 128'(0), 128'(alloc_hit));
        refill(2'd2, 28'h0002020, 1'b1);
        wait_idle();
        @(negedge clk);
        assert (!full) else report_mismatch("full", 128'(0), 128'(full));
        refill(2'd0, 28'h0002000, 1'b0);
        refill(2'd1, 28'h0002010, 1'b1);
        refill(2'd3, 28'h0002030, 1'b0);
        wait_idle();

        test_name = "conflict_urgent";
        stall = 1'b1; // Hold the address phase so several slots are ready at once.
        alloc(28'h0003000);
        alloc(28'h0003010);
        alloc(28'h0003020);
        refill(2'd0, 28'h0003000, 1'b1);
        refill(2'd1, 28'h0003010, 1'b1);
        refill(2'd2, 28'h0003020, 1'b0);
        alloc(28'h0003020);
        assert (alloc_hit && alloc_idx == 2'd2)
            else report_mismatch("alloc_idx", 128'(2), 128'(alloc_idx));
        stall = 1'b0;
        wait_idle();
        assert (drained[drained.size() - 2] == 28'h0003020)
            else report_mismatch("drain order", 128'(28'h0003020),
                                 128'(drained[drained.size() - 2]));

        test_name = "snoop_lookup";
        stall = 1'b1;
        alloc(28'h0004000);
        refill(2'd0, 28'h0004000, 1'b1);
        snoop(28'h0004000, 1'b0);
        assert (snoop_hit && snoop_dirty && snoop_line == make_line(28'h0004000))
            else report_mismatch("snoop_line", make_line(28'h0004000), snoop_line);
        snoop(28'h0004990, 1'b0);
        assert (!snoop_hit) else report_mismatch("snoop_hit", 128'(0), 128'(snoop_hit));

        test_name = "snoop_clean";
        alloc(28'h0005000);
        refill(2'd1, 28'h0005000, 1'b1);
        snoop(28'h0004000, 1'b1); // Active slot, must survive.
        snoop(28'h0004000, 1'b0);
        assert (snoop_hit) else report_error("the line under drain was cleaned");
        snoop(28'h0005000, 1'b1);
        stall = 1'b0;
        wait_idle();
        foreach (drained[i]) begin
            assert (drained[i] != 28'h0005000) else report_error("a cleaned line was drained");
        end
        repeat (2) @(negedge clk);

        $display("** PASS **");
        $finish;
    end

endmodule
